// File: controlPkg.sv
package controlPkg;

    // instruction fields
    typedef logic [31:0] instrT;                   // full instruction word
    typedef logic [5:0]  opcodeT;                  // bits 31:26
    typedef logic [5:0]  functT;                   // bits 5:0, R-type operation
    typedef logic [4:0]  aluOpT;                   // execute-stage ALU operation

    // ALU operation codes, numbering shared with the execute stage
    localparam aluOpT AluNone   = 5'd0;            // no operation
    localparam aluOpT AluAdd    = 5'd1;            // add, also address add
    localparam aluOpT AluAddu   = 5'd2;
    localparam aluOpT AluSub    = 5'd3;
    localparam aluOpT AluMul    = 5'd4;            // low word to rd
    localparam aluOpT AluMult   = 5'd5;            // result to hi/lo
    localparam aluOpT AluMultu  = 5'd6;
    localparam aluOpT AluMadd   = 5'd7;            // hi/lo accumulate
    localparam aluOpT AluMsub   = 5'd8;
    localparam aluOpT AluLui    = 5'd9;
    localparam aluOpT AluMthi   = 5'd10;
    localparam aluOpT AluMtlo   = 5'd11;
    localparam aluOpT AluMfhi   = 5'd12;
    localparam aluOpT AluMflo   = 5'd13;
    localparam aluOpT AluSra    = 5'd15;           // code 14 unused
    localparam aluOpT AluAnd    = 5'd16;
    localparam aluOpT AluOr     = 5'd17;
    localparam aluOpT AluNor    = 5'd18;
    localparam aluOpT AluXor    = 5'd19;
    localparam aluOpT AluSll    = 5'd20;
    localparam aluOpT AluSrl    = 5'd21;
    localparam aluOpT AluSlt    = 5'd22;
    localparam aluOpT AluMov    = 5'd23;           // shared by movn and movz
    localparam aluOpT AluRotrv  = 5'd24;
    localparam aluOpT AluSrav   = 5'd25;
    localparam aluOpT AluSeb    = 5'd26;
    localparam aluOpT AluSltu   = 5'd27;
    localparam aluOpT AluSeh    = 5'd28;
    localparam aluOpT AluSllv   = 5'd29;
    localparam aluOpT AluSrlv   = 5'd30;
    localparam aluOpT AluRotr   = 5'd31;

    // jump kind seen by the fetch stage
    typedef logic [1:0] jumpT;
    localparam jumpT JumpNone     = 2'd0;
    localparam jumpT JumpDirect   = 2'd1;          // j, 26-bit target
    localparam jumpT JumpRegister = 2'd2;          // jr, target from rs
    localparam jumpT JumpLink     = 2'd3;          // jal, return address written

    // branch kind, resolved against the comparison flags
    typedef logic [2:0] branchCondT;
    localparam branchCondT CondNone = 3'd0;        // not a branch
    localparam branchCondT CondEq   = 3'd1;        // beq
    localparam branchCondT CondNe   = 3'd2;        // bne
    localparam branchCondT CondGtz  = 3'd3;        // bgtz
    localparam branchCondT CondLez  = 3'd4;        // blez
    localparam branchCondT CondGez  = 3'd5;        // bgez
    localparam branchCondT CondLtz  = 3'd6;        // bltz

    // register write qualifier for the conditional moves
    typedef logic [1:0] writeCondT;
    localparam writeCondT WriteAlways    = 2'd0;
    localparam writeCondT WriteIfNonZero = 2'd1;   // movn
    localparam writeCondT WriteIfZero    = 2'd2;   // movz

    // execute-stage control word, aluSrc in bit 7
    typedef struct packed {
        logic  aluSrc;                             // 1 selects immediate operand
        aluOpT aluOp;
        logic  regDst;                             // 1 writes rd, 0 writes rt
        logic  regWrite;
    } exCtrlT;

    // comparison results from the register-read stage
    typedef struct packed {
        logic equalVal;                            // rs == rt
        logic gtZero;                              // rs > 0
        logic ltZero;                              // rs < 0
        logic beqz;                                // rt == 0, for movn/movz
    } flagsT;

    // common decoder result, merged downstream
    typedef struct packed {
        logic       hit;                           // decoder owns this opcode
        exCtrlT     exCtrl;
        jumpT       jump;
        branchCondT branchCond;
        writeCondT  writeCond;
    } decodeT;

endpackage

// File: functDecoder.sv
`timescale 1ns/1ps
module functDecoder (
    input  controlPkg::instrT  instruction,
    output controlPkg::decodeT result
);

    controlPkg::opcodeT opcode;      // group select
    controlPkg::functT  funct;       // operation inside SPECIAL/SPECIAL2
    logic [4:0]         shiftField;  // sa field, SPECIAL3 sub-operation

    assign opcode     = instruction[31:26];
    assign funct      = instruction[5:0];
    assign shiftField = instruction[10:6];

    // register-register form, result goes to rd
    function automatic controlPkg::exCtrlT regOp(input controlPkg::aluOpT op);
        controlPkg::exCtrlT ctrl;
        ctrl          = '0;
        ctrl.aluOp    = op;
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        return ctrl;
    endfunction

    always_comb begin
        result = '0;                                              // miss by default
        case (opcode)
            6'b000000: begin                                      // SPECIAL
                result.hit = 1'b1;
                case (funct)
                    6'b100000: result.exCtrl = regOp(controlPkg::AluAdd);     // add
                    6'b100001: result.exCtrl = regOp(controlPkg::AluAddu);    // addu
                    6'b100010: result.exCtrl = regOp(controlPkg::AluSub);     // sub
                    6'b011000: result.exCtrl = regOp(controlPkg::AluMult);    // mult
                    6'b011001: result.exCtrl = regOp(controlPkg::AluMultu);   // multu
                    6'b100100: result.exCtrl = regOp(controlPkg::AluAnd);     // and
                    6'b100101: result.exCtrl = regOp(controlPkg::AluOr);      // or
                    6'b100111: result.exCtrl = regOp(controlPkg::AluNor);     // nor
                    6'b100110: result.exCtrl = regOp(controlPkg::AluXor);     // xor
                    6'b101010: result.exCtrl = regOp(controlPkg::AluSlt);     // slt
                    6'b101011: result.exCtrl = regOp(controlPkg::AluSltu);    // sltu
                    6'b000000: begin                                          // sll
                        if (instruction != '0) begin                          // zero word is nop
                            result.exCtrl = regOp(controlPkg::AluSll);
                        end
                    end
                    6'b000010: begin                                          // srl or rotr
                        if (instruction[21]) begin                            // R bit set
                            result.exCtrl = regOp(controlPkg::AluRotr);
                        end else begin
                            result.exCtrl = regOp(controlPkg::AluSrl);
                        end
                    end
                    6'b000011: result.exCtrl = regOp(controlPkg::AluSra);     // sra
                    6'b000100: result.exCtrl = regOp(controlPkg::AluSllv);    // sllv
                    6'b000110: begin                                          // srlv or rotrv
                        if (instruction[6]) begin                             // R bit of variable form
                            result.exCtrl = regOp(controlPkg::AluRotrv);
                        end else begin
                            result.exCtrl = regOp(controlPkg::AluSrlv);
                        end
                    end
                    6'b000111: result.exCtrl = regOp(controlPkg::AluSrav);    // srav
                    6'b010000: result.exCtrl = regOp(controlPkg::AluMfhi);    // mfhi
                    6'b010010: result.exCtrl = regOp(controlPkg::AluMflo);    // mflo
                    6'b010001: result.exCtrl.aluOp = controlPkg::AluMthi;     // mthi, hi only
                    6'b010011: result.exCtrl.aluOp = controlPkg::AluMtlo;     // mtlo, lo only
                    6'b001011: begin                                          // movn
                        result.exCtrl    = regOp(controlPkg::AluMov);
                        result.writeCond = controlPkg::WriteIfNonZero;
                    end
                    6'b001010: begin                                          // movz
                        result.exCtrl    = regOp(controlPkg::AluMov);
                        result.writeCond = controlPkg::WriteIfZero;
                    end
                    6'b001000: begin                                          // jr
                        result.exCtrl.aluOp = controlPkg::AluAdd;
                        result.jump         = controlPkg::JumpRegister;
                        result.branchCond   = controlPkg::CondNone;           // redirect, not a compare
                    end
                    default: result.exCtrl = '0;                              // unlisted funct
                endcase
            end
            6'b011100: begin                                      // SPECIAL2
                result.hit = 1'b1;
                case (funct)
                    6'b000010: result.exCtrl = regOp(controlPkg::AluMul);     // mul
                    6'b000000: result.exCtrl = regOp(controlPkg::AluMadd);    // madd
                    6'b000100: result.exCtrl = regOp(controlPkg::AluMsub);    // msub
                    default:   result.exCtrl = '0;
                endcase
            end
            6'b011111: begin                                      // SPECIAL3, bshfl group
                result.hit = 1'b1;
                case (shiftField)
                    5'b10000: result.exCtrl = regOp(controlPkg::AluSeb);      // seb
                    5'b11000: result.exCtrl = regOp(controlPkg::AluSeh);      // seh
                    default:  result.exCtrl = '0;
                endcase
            end
            default: result = '0;                                 // opcode decoder's territory
        endcase
    end

endmodule

// File: opcodeDecoder.sv
`timescale 1ns/1ps
module opcodeDecoder (
    input  controlPkg::instrT  instruction,
    output controlPkg::decodeT result
);

    controlPkg::opcodeT opcode;   // bits 31:26
    logic [4:0]         rtField;  // REGIMM sub-opcode

    assign opcode  = instruction[31:26];
    assign rtField = instruction[20:16];

    // immediate form, result goes to rt
    function automatic controlPkg::exCtrlT immOp(input controlPkg::aluOpT op);
        controlPkg::exCtrlT ctrl;
        ctrl          = '0;
        ctrl.aluSrc   = 1'b1;
        ctrl.aluOp    = op;
        ctrl.regWrite = 1'b1;
        return ctrl;
    endfunction

    // store address add, no register write
    function automatic controlPkg::exCtrlT storeOp();
        controlPkg::exCtrlT ctrl;
        ctrl        = '0;
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = controlPkg::AluAdd;
        return ctrl;
    endfunction

    always_comb begin
        result     = '0;
        result.hit = 1'b1;                                        // cleared in default
        case (opcode)
            6'b001000: result.exCtrl = immOp(controlPkg::AluAdd);     // addi
            6'b001001: result.exCtrl = immOp(controlPkg::AluAddu);    // addiu
            6'b001100: result.exCtrl = immOp(controlPkg::AluAnd);     // andi
            6'b001101: result.exCtrl = immOp(controlPkg::AluOr);      // ori
            6'b001110: result.exCtrl = immOp(controlPkg::AluXor);     // xori
            6'b001010: result.exCtrl = immOp(controlPkg::AluSlt);     // slti
            6'b001011: result.exCtrl = immOp(controlPkg::AluSltu);    // sltiu
            6'b001111: result.exCtrl = immOp(controlPkg::AluLui);     // lui
            6'b100011: result.exCtrl = immOp(controlPkg::AluAdd);     // lw
            6'b100001: result.exCtrl = immOp(controlPkg::AluAdd);     // lh
            6'b100000: result.exCtrl = immOp(controlPkg::AluAdd);     // lb
            6'b101011: result.exCtrl = storeOp();                     // sw
            6'b101001: result.exCtrl = storeOp();                     // sh
            6'b101000: result.exCtrl = storeOp();                     // sb
            6'b000100: result.branchCond = controlPkg::CondEq;        // beq
            6'b000101: result.branchCond = controlPkg::CondNe;        // bne
            6'b000111: result.branchCond = controlPkg::CondGtz;       // bgtz
            6'b000110: result.branchCond = controlPkg::CondLez;       // blez
            6'b000001: begin                                          // REGIMM
                case (rtField)
                    5'b00001: result.branchCond = controlPkg::CondGez;    // bgez
                    5'b00000: result.branchCond = controlPkg::CondLtz;    // bltz
                    default:  result.hit        = 1'b0;                   // bltzal etc not decoded
                endcase
            end
            6'b000010: result.jump = controlPkg::JumpDirect;          // j
            6'b000011: begin                                          // jal
                result.jump            = controlPkg::JumpLink;
                result.exCtrl.regWrite = 1'b1;                        // link register
            end
            default: result.hit = 1'b0;                               // unknown or R-type group
        endcase
    end

endmodule

// File: controlMerge.sv
`timescale 1ns/1ps
module controlMerge (
    input  controlPkg::decodeT functResult,
    input  controlPkg::decodeT opcodeResult,
    input  controlPkg::flagsT  flags,
    output controlPkg::exCtrlT controlBits,
    output controlPkg::jumpT   jump,
    output logic               branch,
    output logic               pcSrc
);

    controlPkg::decodeT selected;   // result of the owning decoder
    logic               condTaken;  // branch condition met
    logic               writeOk;    // conditional write allowed

    // groups are disjoint, priority order is arbitrary
    always_comb begin
        if (functResult.hit) begin
            selected = functResult;
        end else if (opcodeResult.hit) begin
            selected = opcodeResult;
        end else begin
            selected = '0;                                    // illegal opcode acts as nop
        end
    end

    always_comb begin
        case (selected.branchCond)
            controlPkg::CondEq:  condTaken = flags.equalVal;
            controlPkg::CondNe:  condTaken = ~flags.equalVal;
            controlPkg::CondGtz: condTaken = flags.gtZero;
            controlPkg::CondLez: condTaken = ~flags.gtZero;   // not greater means <= 0
            controlPkg::CondGez: condTaken = ~flags.ltZero;
            controlPkg::CondLtz: condTaken = flags.ltZero;
            default:             condTaken = 1'b0;            // CondNone and spare codes
        endcase
    end

    // movn/movz qualified by the rt == 0 flag
    always_comb begin
        case (selected.writeCond)
            controlPkg::WriteIfNonZero: writeOk = ~flags.beqz;
            controlPkg::WriteIfZero:    writeOk = flags.beqz;
            default:                    writeOk = 1'b1;
        endcase
    end

    always_comb begin
        controlBits          = selected.exCtrl;
        controlBits.regWrite = selected.exCtrl.regWrite & writeOk;
    end

    assign jump = selected.jump;

    // jr redirects through the branch path in fetch
    assign branch = (selected.branchCond != controlPkg::CondNone)
                  | (selected.jump == controlPkg::JumpRegister);

    assign pcSrc = condTaken;                                 // jr leaves this at 0

endmodule

// File: controller.sv
`timescale 1ns/1ps
module controller (
    input  controlPkg::instrT  instruction,
    input  controlPkg::flagsT  flags,
    output controlPkg::exCtrlT controlBits,
    output controlPkg::jumpT   jump,
    output logic               branch,
    output logic               pcSrc
);

    controlPkg::decodeT functResult;    // SPECIAL, SPECIAL2, SPECIAL3
    controlPkg::decodeT opcodeResult;   // immediate, memory, branch, jump

    functDecoder i_functDecoder (
        .instruction (instruction),
        .result      (functResult)
    );

    opcodeDecoder i_opcodeDecoder (
        .instruction (instruction),
        .result      (opcodeResult)
    );

    controlMerge i_controlMerge (
        .functResult  (functResult),
        .opcodeResult (opcodeResult),
        .flags        (flags),
        .controlBits  (controlBits),
        .jump         (jump),
        .branch       (branch),
        .pcSrc        (pcSrc)
    );

endmodule

// File: controllerRef.svh
`ifndef CONTROLLER_REF_SVH
`define CONTROLLER_REF_SVH

// expected DUT outputs for one instruction
typedef struct packed {
    controlPkg::exCtrlT ctrl;
    controlPkg::jumpT   jump;
    logic               branch;
    logic               pcSrc;
} expectT;

function automatic expectT expectedControl(input controlPkg::instrT instr,
                                           input controlPkg::flagsT fl);
    expectT            e;
    controlPkg::aluOpT alu;
    logic              imm;   // immediate operand
    logic              rd;    // rd destination
    logic              wr;    // register write
    e   = '0;
    alu = controlPkg::AluNone;
    imm = 1'b0;
    rd  = 1'b0;
    wr  = 1'b0;
    case (instr[31:26])
        6'h00: begin
            rd = (instr != '0);                                   // nop keeps all low
            wr = rd;
            case (instr[5:0])
                6'h20: alu = controlPkg::AluAdd;
                6'h21: alu = controlPkg::AluAddu;
                6'h22: alu = controlPkg::AluSub;
                6'h18: alu = controlPkg::AluMult;
                6'h19: alu = controlPkg::AluMultu;
                6'h24: alu = controlPkg::AluAnd;
                6'h25: alu = controlPkg::AluOr;
                6'h27: alu = controlPkg::AluNor;
                6'h26: alu = controlPkg::AluXor;
                6'h2A: alu = controlPkg::AluSlt;
                6'h2B: alu = controlPkg::AluSltu;
                6'h00: alu = rd ? controlPkg::AluSll : controlPkg::AluNone;
                6'h02: alu = instr[21] ? controlPkg::AluRotr : controlPkg::AluSrl;
                6'h03: alu = controlPkg::AluSra;
                6'h04: alu = controlPkg::AluSllv;
                6'h06: alu = instr[6] ? controlPkg::AluRotrv : controlPkg::AluSrlv;
                6'h07: alu = controlPkg::AluSrav;
                6'h10: alu = controlPkg::AluMfhi;
                6'h12: alu = controlPkg::AluMflo;
                6'h11, 6'h13: begin                               // hi/lo only, no gpr
                    alu = instr[1] ? controlPkg::AluMtlo : controlPkg::AluMthi;
                    rd  = 1'b0;
                    wr  = 1'b0;
                end
                6'h0A, 6'h0B: begin
                    alu = controlPkg::AluMov;
                    wr  = instr[0] ? ~fl.beqz : fl.beqz;          // movn : movz
                end
                6'h08: begin                                      // jr
                    alu      = controlPkg::AluAdd;
                    rd       = 1'b0;
                    wr       = 1'b0;
                    e.jump   = controlPkg::JumpRegister;
                    e.branch = 1'b1;
                end
                default: begin
                    rd = 1'b0;
                    wr = 1'b0;
                end
            endcase
        end
        6'h1C, 6'h1F: begin                                       // SPECIAL2 / SPECIAL3
            rd = 1'b1;
            wr = 1'b1;
            if (!instr[26]) begin
                case (instr[5:0])
                    6'h02: alu = controlPkg::AluMul;
                    6'h00: alu = controlPkg::AluMadd;
                    6'h04: alu = controlPkg::AluMsub;
                    default: alu = controlPkg::AluNone;
                endcase
            end else if (instr[10:6] == 5'h10) begin
                alu = controlPkg::AluSeb;
            end else if (instr[10:6] == 5'h18) begin
                alu = controlPkg::AluSeh;
            end
            if (alu == controlPkg::AluNone) begin                 // unlisted sub-op
                rd = 1'b0;
                wr = 1'b0;
            end
        end
        6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E, 6'h0F, 6'h20, 6'h21, 6'h23: begin
            imm = 1'b1;
            wr  = 1'b1;
            case (instr[31:26])
                6'h09: alu = controlPkg::AluAddu;
                6'h0A: alu = controlPkg::AluSlt;
                6'h0B: alu = controlPkg::AluSltu;
                6'h0C: alu = controlPkg::AluAnd;
                6'h0D: alu = controlPkg::AluOr;
                6'h0E: alu = controlPkg::AluXor;
                6'h0F: alu = controlPkg::AluLui;
                default: alu = controlPkg::AluAdd;                // addi and loads
            endcase
        end
        6'h28, 6'h29, 6'h2B: begin                                // stores
            imm = 1'b1;
            alu = controlPkg::AluAdd;
        end
        6'h04: e.branch = 1'b1;
        6'h05: e.branch = 1'b1;
        6'h06: e.branch = 1'b1;
        6'h07: e.branch = 1'b1;
        6'h01: e.branch = (instr[20:17] == 4'h0);                 // bltz / bgez only
        6'h02: e.jump = controlPkg::JumpDirect;
        6'h03: begin
            e.jump = controlPkg::JumpLink;
            wr     = 1'b1;                                        // link write
        end
        default: e = '0;
    endcase
    case (instr[31:26])
        6'h04: e.pcSrc = fl.equalVal;
        6'h05: e.pcSrc = ~fl.equalVal;
        6'h07: e.pcSrc = fl.gtZero;
        6'h06: e.pcSrc = ~fl.gtZero;
        6'h01: e.pcSrc = e.branch & (instr[16] ? ~fl.ltZero : fl.ltZero);
        default: e.pcSrc = 1'b0;
    endcase
    e.ctrl = '{imm, alu, rd, wr};
    return e;
endfunction

`endif

// File: controllerTb.sv
`timescale 1ns/1ps
module controllerTb;

    `include "controllerRef.svh"

    logic               clk;
    logic               reset = 1'b1;          // testbench only, DUT has no state
    controlPkg::instrT  instruction;
    controlPkg::flagsT  flags;
    controlPkg::exCtrlT controlBits;
    controlPkg::jumpT   jump;
    logic               branch;
    logic               pcSrc;

    logic   checkEn;                            // compare at next rising edge
    logic   bad;
    expectT want;
    int     seed = 32'h17a0;
    int     checked = 0;
    int     failCount = 0;
    int     startChecked = 0;
    int     startFails = 0;
    int     waitCycles;

    // curated stimulus
    logic [31:0] nopWords [9] = '{32'h0000_0000, 32'h4000_0000, 32'h9000_1234,
                                  32'hFC00_0000, 32'h0000_000C, 32'h0000_0009,
                                  32'h7000_0001, 32'h7C00_00A0, 32'h0410_0000};
    logic [5:0] specialFn [21] = '{6'h20, 6'h21, 6'h22, 6'h18, 6'h19, 6'h24, 6'h25,
                                   6'h27, 6'h26, 6'h2A, 6'h2B, 6'h00, 6'h02, 6'h03,
                                   6'h04, 6'h06, 6'h07, 6'h10, 6'h12, 6'h11, 6'h13};
    logic [5:0] special2Fn [3] = '{6'h02, 6'h00, 6'h04};
    logic [4:0] special3Sa [2] = '{5'h10, 5'h18};         // seb, seh
    logic [5:0] immOps [14]    = '{6'h08, 6'h09, 6'h0C, 6'h0D, 6'h0E, 6'h0A, 6'h0B,
                                   6'h0F, 6'h23, 6'h21, 6'h20, 6'h2B, 6'h29, 6'h28};
    logic [5:0] branchOps [4]  = '{6'h04, 6'h05, 6'h07, 6'h06};
    logic [5:0] moveFn [2]     = '{6'h0B, 6'h0A};         // movn, movz

    controller i_dut (
        .instruction (instruction),
        .flags       (flags),
        .controlBits (controlBits),
        .jump        (jump),
        .branch      (branch),
        .pcSrc       (pcSrc)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (3) @(negedge clk);
        reset = 1'b0;
    end

    function automatic controlPkg::flagsT randomFlags();
        logic [31:0] r;
        r = $random(seed);
        return controlPkg::flagsT'(r[3:0]);
    endfunction

    function automatic controlPkg::instrT randomWord();
        return $random(seed);
    endfunction

    task automatic driveInstr(input controlPkg::instrT instr, input controlPkg::flagsT fl);
        @(negedge clk);
        instruction = instr;
        flags       = fl;
        checkEn     = 1'b1;
    endtask

    // random fields around a fixed opcode
    task automatic sendOpcode(input logic [5:0] op);
        controlPkg::instrT w;
        w        = randomWord();
        w[31:26] = op;
        driveInstr(w, randomFlags());
    endtask

    task automatic sendFunct(input logic [5:0] op, input logic [5:0] fn);
        controlPkg::instrT w;
        w        = randomWord();
        w[31:26] = op;
        w[5:0]   = fn;
        driveInstr(w, randomFlags());
    endtask

    task automatic finishTest(input string name);
        @(negedge clk);                         // last compare has run
        checkEn = 1'b0;
        $display("test %-9s done: %0d checked, %0d failed", name,
                 checked - startChecked, failCount - startFails);
        startChecked = checked;
        startFails   = failCount;
    endtask

    // output compare, inputs settled since the falling edge
    always @(posedge clk) begin
        if (checkEn) begin
            want = expectedControl(instruction, flags);
            bad  = 1'b0;
            if (controlBits !== want.ctrl) begin
                $display("[FAIL] t=%0t controlBits expected %h got %h (instr %h)",
                         $time, want.ctrl, controlBits, instruction);
                bad = 1'b1;
            end
            if (jump !== want.jump) begin
                $display("[FAIL] t=%0t jump expected %h got %h (instr %h)",
                         $time, want.jump, jump, instruction);
                bad = 1'b1;
            end
            if (branch !== want.branch) begin
                $display("[FAIL] t=%0t branch expected %b got %b (instr %h)",
                         $time, want.branch, branch, instruction);
                bad = 1'b1;
            end
            if (pcSrc !== want.pcSrc) begin
                $display("[FAIL] t=%0t pcSrc expected %b got %b (instr %h flags %b)",
                         $time, want.pcSrc, pcSrc, instruction, flags);
                bad = 1'b1;
            end
            checked = checked + 1;
            if (bad) begin
                failCount = failCount + 1;
            end
        end
    end

    task automatic runAllTests();
        controlPkg::instrT w;
        controlPkg::flagsT fl;
        foreach (nopWords[i]) driveInstr(nopWords[i], randomFlags());
        finishTest("nop");
        foreach (specialFn[i]) repeat (3) sendFunct(6'h00, specialFn[i]);
        foreach (special2Fn[i]) repeat (3) sendFunct(6'h1C, special2Fn[i]);
        foreach (special3Sa[i]) begin
            repeat (3) begin
                w        = randomWord();
                w[31:26] = 6'h1F;
                w[10:6]  = special3Sa[i];
                w[5:0]   = 6'h20;               // bshfl
                driveInstr(w, randomFlags());
            end
        end
        finishTest("rtype");
        foreach (immOps[i]) repeat (3) sendOpcode(immOps[i]);
        finishTest("immediate");
        foreach (branchOps[i]) repeat (8) sendOpcode(branchOps[i]);
        for (int rt = 0; rt < 2; rt++) begin    // bltz, bgez
            repeat (8) begin
                w        = randomWord();
                w[31:26] = 6'h01;
                w[20:16] = rt[4:0];
                driveInstr(w, randomFlags());
            end
        end
        finishTest("branch");
        repeat (3) sendOpcode(6'h02);
        repeat (3) sendOpcode(6'h03);
        repeat (3) sendFunct(6'h00, 6'h08);     // jr
        finishTest("jump");
        foreach (moveFn[i]) begin
            for (int b = 0; b < 2; b++) begin
                repeat (3) begin
                    w        = randomWord();
                    w[31:26] = 6'h00;
                    w[5:0]   = moveFn[i];
                    fl       = randomFlags();
                    fl.beqz  = b[0];
                    driveInstr(w, fl);
                end
            end
        end
        finishTest("condmove");
    endtask

    initial begin
        instruction = '0;
        flags       = '0;
        checkEn     = 1'b0;
        waitCycles  = 0;
        while (reset && waitCycles < 20) begin
            @(negedge clk);
            waitCycles = waitCycles + 1;
        end
        if (reset) begin
            $display("reset was not released within 20 cycles");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            runAllTests();
            $display("summary: %0d passed, %0d failed", checked - failCount, failCount);
            if (failCount == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+.
controlPkg.sv
functDecoder.sv
opcodeDecoder.sv
controlMerge.sv
controller.sv
controllerTb.sv

// File: run.sh
#!/bin/bash
# build and run the controller testbench, result decided from sim.log
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module controllerTb \
    -o controllerSim \
    && ./obj_dir/controllerSim > sim.log 2>&1 \
    || echo "build or run error"
cat sim.log 2>/dev/null
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
